//--- src/rc4_pkg.sv
package rc4_pkg;

	localparam int MSG_LEN = 32;            // ciphertext bytes per search
	localparam int KEY_W = 24;              // searched key width
	localparam int KEY_BYTES = 3;           // bytes in one key

	localparam logic [7:0] CHAR_SPACE = 8'd32;  // ascii space
	localparam logic [7:0] CHAR_LO = 8'd97;     // 'a'
	localparam logic [7:0] CHAR_HI = 8'd122;    // 'z'

	// key as counter or as bytes, byte 0 is the top byte
	typedef union packed {
		logic [KEY_W-1:0] value;                // whole key count
		logic [0:KEY_BYTES-1][7:0] bytes;       // key bytes, msb first
	} key_word_u;

	// one access to the rc4 state memory
	typedef struct packed {
		logic en;           // port active this cycle
		logic we;           // write, else read
		logic [7:0] addr;   // state index
		logic [7:0] wdata;  // write value
	} s_port_t;

	// one write into a message memory
	typedef struct packed {
		logic we;           // write strobe
		logic [4:0] addr;   // byte index
		logic [7:0] data;   // byte value
	} msg_wr_t;

endpackage

//--- src/key_search_ctrl.sv
`timescale 1ns/100ps

module key_search_ctrl
	import rc4_pkg::*;
(
	input logic clok,
	input logic resetm,
	input logic start,              // begin a run
	input key_word_u key_lo,        // first key of range
	input key_word_u key_hi,        // last key of range
	input logic ks_done,            // schedule finished
	input logic new_char,           // plaintext byte strobe
	input logic dec_done,           // all bytes produced
	input logic [7:0] char_out,     // byte to check
	output logic ks_start,          // kick key schedule
	output logic dec_start,         // kick decrypt
	output logic abort,             // bad byte, drop this key
	output key_word_u key_cur,      // key under test
	output logic found_key,
	output logic done,
	output logic last_key
);

	typedef enum logic [2:0] {
		CT_IDLE,
		CT_SCHEDULE,
		CT_DECRYPT,
		CT_NEXT_KEY,
		CT_FOUND,
		CT_EXHAUSTED
	} ctrl_state_t;

	ctrl_state_t state;
	logic [5:0] pass_cnt;           // bytes passed for this key
	logic char_ok;
	logic key_at_hi;
	logic can_start;

	// lowercase letter or space
	assign char_ok = ((char_out >= CHAR_LO) && (char_out <= CHAR_HI)) ||
		(char_out == CHAR_SPACE);
	assign key_at_hi = (key_cur.value == key_hi.value);   // range end reached
	assign can_start = (state == CT_IDLE) || (state == CT_FOUND) ||
		(state == CT_EXHAUSTED);   // not busy

	always_ff @(posedge clok, negedge resetm) begin
		if (!resetm) begin
			state <= CT_IDLE;
			key_cur <= '0;
			pass_cnt <= '0;
			ks_start <= 1'b0;
			dec_start <= 1'b0;
			abort <= 1'b0;
			found_key <= 1'b0;
			done <= 1'b0;
			last_key <= 1'b0;
		end else begin
			ks_start <= 1'b0;   // pulses by default
			dec_start <= 1'b0;
			abort <= 1'b0;
			if (start && can_start) begin
				key_cur <= key_lo;  // first key of new range
				ks_start <= 1'b1;
				found_key <= 1'b0;  // clear old outcome
				done <= 1'b0;
				last_key <= 1'b0;
				state <= CT_SCHEDULE;
			end else begin
				case (state)
					CT_SCHEDULE: begin
						if (ks_done) begin
							pass_cnt <= '0;
							dec_start <= 1'b1;
							state <= CT_DECRYPT;
						end
					end
					CT_DECRYPT: begin
						if (new_char) begin
							if (char_ok) begin
								pass_cnt <= pass_cnt + 6'd1;
							end else begin
								abort <= 1'b1;  // stop decrypt right away
								if (key_at_hi) begin
									last_key <= 1'b1;   // nothing left to try
									state <= CT_EXHAUSTED;
								end else begin
									state <= CT_NEXT_KEY;
								end
							end
						end else if (dec_done && (pass_cnt == 6'(MSG_LEN))) begin
							found_key <= 1'b1;  // every byte was text
							done <= 1'b1;
							state <= CT_FOUND;
						end
					end
					CT_NEXT_KEY: begin
						key_cur.value <= key_cur.value + 1'b1;  // step as a counter
						ks_start <= 1'b1;
						state <= CT_SCHEDULE;
					end
					default: state <= state;    // idle, found, exhausted hold
				endcase
			end
		end
	end

endmodule

//--- src/key_schedule.sv
`timescale 1ns/100ps

module key_schedule
	import rc4_pkg::*;
(
	input logic clok,
	input logic resetm,
	input logic ks_start,           // begin fill + swaps
	input key_word_u key,           // held stable by controller
	input logic [7:0] s_rdata,      // state read data, 1 cycle late
	output s_port_t s_port,         // state memory access
	output logic ks_done            // one cycle pulse
);

	typedef enum logic [2:0] {
		KS_IDLE,
		KS_FILL,
		KS_RD_I,
		KS_RD_J,
		KS_WR_J,
		KS_WR_I
	} ks_state_t;

	ks_state_t state;
	logic [7:0] i;
	logic [7:0] j;
	logic [1:0] kidx;               // i mod 3, kept as a counter
	logic [7:0] si;                 // held s[i]
	logic [7:0] sj;                 // held s[j]
	logic [7:0] j_next;

	assign j_next = j + s_rdata + key.bytes[kidx];  // s_rdata is s[i] in rd_j

	always_ff @(posedge clok, negedge resetm) begin
		if (!resetm) begin
			state <= KS_IDLE;
			i <= '0;
			j <= '0;
			kidx <= '0;
			ks_done <= 1'b0;
		end else begin
			ks_done <= 1'b0;
			case (state)
				KS_IDLE: begin
					if (ks_start) begin
						i <= '0;
						state <= KS_FILL;
					end
				end
				KS_FILL: begin
					i <= i + 8'd1;  // wraps to 0 for swap loop
					if (i == 8'hff) begin
						j <= '0;
						kidx <= '0;
						state <= KS_RD_I;
					end
				end
				KS_RD_I: state <= KS_RD_J;
				KS_RD_J: begin
					j <= j_next;
					state <= KS_WR_J;
				end
				KS_WR_J: state <= KS_WR_I;
				KS_WR_I: begin
					i <= i + 8'd1;
					kidx <= (kidx == 2'(KEY_BYTES - 1)) ? 2'd0 : kidx + 2'd1;
					if (i == 8'hff) begin
						ks_done <= 1'b1;    // 256 swaps done
						state <= KS_IDLE;
					end else begin
						state <= KS_RD_I;
					end
				end
				default: state <= KS_IDLE;
			endcase
		end
	end

	// swap temporaries
	always_ff @(posedge clok) begin
		if (state == KS_RD_J) si <= s_rdata;
		if (state == KS_WR_J) sj <= s_rdata;
	end

	always_comb begin
		s_port = '0;
		case (state)
			KS_FILL: s_port = '{en: 1'b1, we: 1'b1, addr: i, wdata: i};  // s[i] = i
			KS_RD_I: s_port = '{en: 1'b1, we: 1'b0, addr: i, wdata: 8'd0};
			KS_RD_J: s_port = '{en: 1'b1, we: 1'b0, addr: j_next, wdata: 8'd0};
			KS_WR_J: s_port = '{en: 1'b1, we: 1'b1, addr: j, wdata: si};    // s[j] = old s[i]
			KS_WR_I: s_port = '{en: 1'b1, we: 1'b1, addr: i, wdata: sj};    // s[i] = old s[j]
			default: s_port = '0;
		endcase
	end

endmodule

//--- src/stream_decrypt.sv
`timescale 1ns/100ps

module stream_decrypt
	import rc4_pkg::*;
(
	input logic clok,
	input logic resetm,
	input logic dec_start,          // begin keystream
	input logic abort,              // controller rejected a byte
	input logic [7:0] s_rdata,      // state read data
	input logic [7:0] cipher_rdata, // ciphertext byte k
	output s_port_t s_port,
	output logic [4:0] cipher_raddr,
	output msg_wr_t plain_wr,       // plaintext store
	output logic new_char,
	output logic [7:0] char_out,
	output logic [4:0] char_idx,
	output logic dec_done
);

	typedef enum logic [2:0] {
		SD_IDLE,
		SD_RD_I,
		SD_RD_J,
		SD_WR_J,
		SD_RD_T,
		SD_WR_I
	} sd_state_t;

	sd_state_t state;
	logic [7:0] i;
	logic [7:0] j;
	logic [4:0] k;                  // message byte index
	logic [7:0] si;
	logic [7:0] sj;
	logic [7:0] j_next;
	logic [7:0] t_addr;
	logic [7:0] ks_byte;

	assign j_next = j + s_rdata;    // s_rdata holds s[i] in rd_j
	assign t_addr = si + sj;
	// s[i] not yet rewritten when s[t] is read, so forward it
	assign ks_byte = (t_addr == i) ? sj : s_rdata;

	always_ff @(posedge clok, negedge resetm) begin
		if (!resetm) begin
			state <= SD_IDLE;
			i <= '0;
			j <= '0;
			k <= '0;
			dec_done <= 1'b0;
		end else begin
			dec_done <= 1'b0;
			if (abort) begin
				state <= SD_IDLE;   // key rejected
			end else begin
				case (state)
					SD_IDLE: begin
						if (dec_start) begin
							i <= '0;
							j <= '0;
							k <= '0;
							state <= SD_RD_I;
						end
					end
					SD_RD_I: begin
						i <= i + 8'd1;
						state <= SD_RD_J;
					end
					SD_RD_J: begin
						j <= j_next;
						state <= SD_WR_J;
					end
					SD_WR_J: state <= SD_RD_T;
					SD_RD_T: state <= SD_WR_I;
					SD_WR_I: begin
						k <= k + 5'd1;
						if (k == 5'(MSG_LEN - 1)) begin
							dec_done <= 1'b1;   // last byte out
							state <= SD_IDLE;
						end else begin
							state <= SD_RD_I;
						end
					end
					default: state <= SD_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clok) begin
		if (state == SD_RD_J) si <= s_rdata;
		if (state == SD_WR_J) sj <= s_rdata;
	end

	always_comb begin
		s_port = '0;
		case (state)
			SD_RD_I: s_port = '{en: 1'b1, we: 1'b0, addr: i + 8'd1, wdata: 8'd0};
			SD_RD_J: s_port = '{en: 1'b1, we: 1'b0, addr: j_next, wdata: 8'd0};
			SD_WR_J: s_port = '{en: 1'b1, we: 1'b1, addr: j, wdata: si};
			SD_RD_T: s_port = '{en: 1'b1, we: 1'b0, addr: t_addr, wdata: 8'd0};
			SD_WR_I: s_port = '{en: 1'b1, we: 1'b1, addr: i, wdata: sj};
			default: s_port = '0;
		endcase
	end

	assign cipher_raddr = k;        // stable for all 5 cycles of a byte
	assign new_char = (state == SD_WR_I);
	assign char_out = ks_byte ^ cipher_rdata;
	assign char_idx = k;
	assign plain_wr = '{we: new_char, addr: k, data: char_out};

endmodule

//--- src/s_ram.sv
`timescale 1ns/100ps

module s_ram
	import rc4_pkg::*;
(
	input logic clok,
	input s_port_t ks_port,         // key schedule side
	input s_port_t dec_port,        // decrypt side
	output logic [7:0] rdata        // registered read
);

	logic [7:0] mem [256];
	s_port_t port;

	// schedule wins, never both active anyway
	assign port = ks_port.en ? ks_port : dec_port;

	always_ff @(posedge clok) begin
		if (port.en) begin
			if (port.we) begin
				mem[port.addr] <= port.wdata;
			end
			rdata <= mem[port.addr];    // old data on a write
		end
	end

endmodule

//--- src/msg_ram.sv
`timescale 1ns/100ps

module msg_ram
	import rc4_pkg::*;
(
	input logic clok,
	input msg_wr_t wr,              // write port
	input logic [4:0] raddr,
	output logic [7:0] rdata        // valid 1 cycle after raddr
);

	logic [7:0] mem [MSG_LEN];

	always_ff @(posedge clok) begin
		if (wr.we) begin
			mem[wr.addr] <= wr.data;
		end
		rdata <= mem[raddr];
	end

endmodule

//--- src/rc4_crack_top.sv
`timescale 1ns/100ps

module rc4_crack_top
	import rc4_pkg::*;
(
	input logic clok,
	input logic resetm,
	input logic start,
	input key_word_u key_lo,
	input key_word_u key_hi,
	input msg_wr_t cipher_wr,       // ciphertext load
	input logic [4:0] plain_raddr,  // plaintext readback
	output logic [7:0] plain_rdata,
	output key_word_u key_cur,
	output logic found_key,
	output logic done,
	output logic last_key
);

	logic ks_start;
	logic ks_done;
	logic dec_start;
	logic dec_done;
	logic abort;
	logic new_char;
	logic [7:0] char_out;
	logic [7:0] s_rdata;
	logic [7:0] cipher_rdata;
	logic [4:0] cipher_raddr;
	s_port_t ks_port;
	s_port_t dec_port;
	msg_wr_t plain_wr;

	key_search_ctrl ctrl0 (
		.clok(clok), .resetm(resetm), .start(start),
		.key_lo(key_lo), .key_hi(key_hi),
		.ks_done(ks_done), .new_char(new_char), .dec_done(dec_done),
		.char_out(char_out), .ks_start(ks_start), .dec_start(dec_start),
		.abort(abort), .key_cur(key_cur),
		.found_key(found_key), .done(done), .last_key(last_key)
	);

	key_schedule ks0 (
		.clok(clok), .resetm(resetm), .ks_start(ks_start), .key(key_cur),
		.s_rdata(s_rdata), .s_port(ks_port), .ks_done(ks_done)
	);

	stream_decrypt dec0 (
		.clok(clok), .resetm(resetm), .dec_start(dec_start), .abort(abort),
		.s_rdata(s_rdata), .cipher_rdata(cipher_rdata), .s_port(dec_port),
		.cipher_raddr(cipher_raddr), .plain_wr(plain_wr), .new_char(new_char),
		.char_out(char_out), .char_idx(), .dec_done(dec_done)
	);

	s_ram s_mem (.clok(clok), .ks_port(ks_port), .dec_port(dec_port), .rdata(s_rdata));

	msg_ram cipher_mem (.clok(clok), .wr(cipher_wr), .raddr(cipher_raddr), .rdata(cipher_rdata));

	msg_ram plain_mem (.clok(clok), .wr(plain_wr), .raddr(plain_raddr), .rdata(plain_rdata));

endmodule

//--- include/rc4_model.svh
`ifndef RC4_MODEL_SVH
`define RC4_MODEL_SVH

typedef logic [7:0] msg_bytes_t [rc4_pkg::MSG_LEN];    // one whole message

// rc4 is symmetric, same routine encrypts and decrypts
function automatic msg_bytes_t rc4_xcrypt(input msg_bytes_t din,
	input logic [rc4_pkg::KEY_W-1:0] key);
	logic [7:0] s [256];
	logic [7:0] kb [rc4_pkg::KEY_BYTES];
	logic [7:0] i;
	logic [7:0] j;
	logic [7:0] tmp;
	msg_bytes_t dout;
	kb[0] = key[23:16];     // byte 0 is the top byte
	kb[1] = key[15:8];
	kb[2] = key[7:0];
	for (int n = 0; n < 256; n++) begin
		s[n] = n[7:0];  // identity fill
	end
	j = 8'd0;
	for (int n = 0; n < 256; n++) begin
		j = j + s[n] + kb[n % rc4_pkg::KEY_BYTES];
		tmp = s[n];
		s[n] = s[j];
		s[j] = tmp;
	end
	i = 8'd0;
	j = 8'd0;
	for (int k = 0; k < rc4_pkg::MSG_LEN; k++) begin
		i = i + 8'd1;
		j = j + s[i];
		tmp = s[i];
		s[i] = s[j];
		s[j] = tmp;
		dout[k] = din[k] ^ s[8'(s[i] + s[j])];  // keystream xor
	end
	return dout;
endfunction

// same rule as the hardware check
function automatic bit rc4_valid_byte(input logic [7:0] c);
	return ((c >= rc4_pkg::CHAR_LO) && (c <= rc4_pkg::CHAR_HI)) ||
		(c == rc4_pkg::CHAR_SPACE);
endfunction

`endif

//--- tests/rc4_crack_tb.sv
`timescale 1ns/100ps

module rc4_crack_tb
	import rc4_pkg::*;
();

	`include "rc4_model.svh"

	localparam int RANGE_LEN = 8;          // keys per search that should hit
	localparam int EMPTY_LEN = 4;          // keys in the range with no hit
	localparam int TOTAL_KEYS = 2 * RANGE_LEN + EMPTY_LEN;
	localparam int CYCLE_LIMIT = TOTAL_KEYS * 1500 + 2000;

	logic clok;
	logic resetm;
	logic start;
	key_word_u key_lo;
	key_word_u key_hi;
	msg_wr_t cipher_wr;
	logic [4:0] plain_raddr;
	logic [7:0] plain_rdata;
	key_word_u key_cur;
	logic found_key;
	logic done;
	logic last_key;

	bit started;                       // set at the first start pulse
	bit expect_exhaust;                // outcome the model predicts
	logic [KEY_W-1:0] exp_key;
	logic [KEY_W-1:0] exp_hi;
	msg_bytes_t cipher_msg;            // ciphertext in the DUT
	msg_bytes_t exp_plain;
	logic rd_req;                      // readback address issued
	logic [7:0] exp_rd;                // byte due one read later
	logic char_bad;
	int cycle_cnt = 0;

	rc4_crack_top dut0 (
		.clok(clok), .resetm(resetm), .start(start),
		.key_lo(key_lo), .key_hi(key_hi), .cipher_wr(cipher_wr),
		.plain_raddr(plain_raddr), .plain_rdata(plain_rdata), .key_cur(key_cur),
		.found_key(found_key), .done(done), .last_key(last_key)
	);

	initial begin
		clok = 1'b0;
		forever #5 clok = ~clok;
	end

	// watchdog sized from the keys all runs try
	always @(posedge clok) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) report_failure("run did not finish within the cycle limit");
	end

	// strobed byte that the check must reject
	assign char_bad = dut0.new_char && !rc4_valid_byte(dut0.char_out);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	a_idle_flags: assert property (@(posedge clok) disable iff (!resetm)
		!started |-> !(done || found_key || last_key))
		else report_failure("outcome flag raised before any start");
	// outcome of the previous run is gone one cycle after start
	a_start_clears: assert property (@(posedge clok) disable iff (!resetm)
		start |=> !(done || found_key || last_key))
		else report_failure("a new start did not clear the outcome flags");
	a_found_kind: assert property (@(posedge clok) disable iff (!resetm)
		$rose(done) |-> (found_key && !expect_exhaust))
		else report_failure("done rose where no key was expected or found_key was low");
	a_found_key: assert property (@(posedge clok) disable iff (!resetm)
		$rose(done) |-> (key_cur.value == exp_key))
		else report_failure($sformatf("Error: key_cur = 0x%06h, expected 0x%06h",
			$sampled(key_cur.value), exp_key));
	a_exhaust_kind: assert property (@(posedge clok) disable iff (!resetm)
		$rose(last_key) |-> expect_exhaust)
		else report_failure("last_key rose although the model found a key in range");
	a_last_not_done: assert property (@(posedge clok) disable iff (!resetm)
		last_key |-> !done)
		else report_failure("done and last_key were high together");
	a_exhaust_key: assert property (@(posedge clok) disable iff (!resetm)
		$rose(last_key) |-> (key_cur.value == exp_hi))
		else report_failure($sformatf("Error: key_cur = 0x%06h, expected 0x%06h",
			$sampled(key_cur.value), exp_hi));
	a_readback: assert property (@(posedge clok) disable iff (!resetm)
		rd_req |=> (plain_rdata == $past(exp_rd)))
		else report_failure($sformatf("Error: plain_rdata = 0x%02h, expected 0x%02h",
			$sampled(plain_rdata), $past(exp_rd)));
	// abort must mirror the character rule one cycle later
	a_abort: assert property (@(posedge clok) disable iff (!resetm)
		dut0.abort == $past(char_bad))
		else report_failure($sformatf("Error: abort = 0x%h, expected 0x%h",
			$sampled(dut0.abort), $past(char_bad)));

	function automatic bit all_valid(input msg_bytes_t pt);
		for (int n = 0; n < MSG_LEN; n++) begin
			if (!rc4_valid_byte(pt[n])) return 1'b0;
		end
		return 1'b1;
	endfunction

	// -1 when nothing in lo..hi decrypts to text
	function automatic int first_valid_key(input msg_bytes_t ct, input int lo, input int hi);
		for (int k = lo; k <= hi; k++) begin
			if (all_valid(rc4_xcrypt(ct, k[KEY_W-1:0]))) return k;
		end
		return -1;
	endfunction

	function automatic msg_bytes_t random_text();
		msg_bytes_t t;
		int unsigned r;
		for (int n = 0; n < MSG_LEN; n++) begin
			r = $urandom_range(0, 26);
			t[n] = (r == 26) ? CHAR_SPACE : CHAR_LO + 8'(r);   // letter or space
		end
		return t;
	endfunction

	task automatic load_cipher(input msg_bytes_t ct);
		for (int k = 0; k < MSG_LEN; k++) begin
			@(posedge clok);
			cipher_wr <= '{we: 1'b1, addr: k[4:0], data: ct[k]};
		end
		@(posedge clok);
		cipher_wr <= '0;
	endtask

	task automatic run_search(input logic [KEY_W-1:0] lo, input logic [KEY_W-1:0] hi);
		started = 1'b1;
		@(posedge clok);
		key_lo.value <= lo;
		key_hi.value <= hi;
		start <= 1'b1;
		@(posedge clok);
		start <= 1'b0;
		@(negedge clok);
		while (!(done || last_key)) @(negedge clok);   // until found or exhausted
	endtask

	task automatic read_plain();
		for (int a = 0; a < MSG_LEN; a++) begin
			@(posedge clok);
			plain_raddr <= a[4:0];
			exp_rd <= exp_plain[a];
			rd_req <= 1'b1;
		end
		@(posedge clok);
		rd_req <= 1'b0;
		repeat (2) @(posedge clok);   // let the last compare happen
	endtask

	// random text and secret key, then search a range around it
	task automatic crack_and_check();
		msg_bytes_t pt;
		logic [KEY_W-1:0] secret;
		logic [KEY_W-1:0] lo;
		int hit;
		pt = random_text();
		secret = KEY_W'($urandom_range(16, 24'hffffe0));
		lo = secret - KEY_W'($urandom_range(0, RANGE_LEN - 1));
		cipher_msg = rc4_xcrypt(pt, secret);
		hit = first_valid_key(cipher_msg, lo, lo + RANGE_LEN - 1);
		if (hit < 0) report_failure("model found no valid key in its own range");
		exp_key = hit[KEY_W-1:0];
		exp_plain = rc4_xcrypt(cipher_msg, exp_key);
		expect_exhaust = 1'b0;
		load_cipher(cipher_msg);
		run_search(lo, lo + RANGE_LEN - 1);
		read_plain();
	endtask

	initial begin
		logic [KEY_W-1:0] lo;
		int tries;
		resetm = 1'b0;
		start = 1'b0;
		key_lo = '0;
		key_hi = '0;
		cipher_wr = '0;
		plain_raddr = '0;
		rd_req = 1'b0;
		exp_rd = '0;
		started = 1'b0;
		expect_exhaust = 1'b0;
		void'($urandom(64284));
		repeat (2) @(posedge clok);
		resetm <= 1'b1;
		repeat (4) @(posedge clok);    // idle flags watched meanwhile
		crack_and_check();
		// same ciphertext over a range just past the hit with no valid key
		lo = exp_key + 1'b1;
		tries = 0;
		while (first_valid_key(cipher_msg, lo, lo + EMPTY_LEN - 1) >= 0) begin
			lo = lo + EMPTY_LEN;
			tries++;
			if (tries > 8) report_failure("model found no key range without a valid key");
		end
		exp_hi = lo + EMPTY_LEN - 1;
		expect_exhaust = 1'b1;
		run_search(lo, exp_hi);
		repeat (4) @(posedge clok);
		crack_and_check();             // restart must clear last_key
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- rc4_crack.f
+incdir+include
src/rc4_pkg.sv
src/key_search_ctrl.sv
src/key_schedule.sv
src/stream_decrypt.sv
src/s_ram.sv
src/msg_ram.sv
src/rc4_crack_top.sv
tests/rc4_crack_tb.sv
